// ==== include/debug_params.svh ====
`ifndef DEBUG_PARAMS_SVH
`define DEBUG_PARAMS_SVH

// command bytes received over the uart
`define DU_CMD_WRITE_IM     8'h01
`define DU_CMD_SEND_INFO    8'h02
`define DU_CMD_STEP_MODE    8'h03
`define DU_CMD_STEP         8'h04
`define DU_CMD_CONTINUE     8'h05

// bytes written by one load command
`define DU_IM_BYTES         64

// words sent in each dump
`define DU_DM_WORDS         32
`define DU_RB_WORDS         32

`endif

// ==== logic/debug_pkg.sv ====
package debug_pkg;

    typedef logic [7:0]  byte_t;        // uart byte
    typedef logic [31:0] word_t;        // pc, memory or register value
    typedef logic [7:0]  im_addr_t;     // instruction memory byte address
    typedef logic [4:0]  dm_addr_t;     // data memory word address
    typedef logic [4:0]  rb_addr_t;     // register number

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        READY,
        RUN,
        STEP_WAIT,
        STEP_EXEC,
        DUMP
    } ctrl_state_t;

    // order in which a dump walks the state
    typedef enum logic [1:0] {
        PC,
        DM,
        RB
    } dump_src_t;

endpackage

// ==== logic/word_if.sv ====
`timescale 1ns/1ps

// dump words from the sequencer to the byte transmitter
interface word_if;
    logic             valid;
    logic             ready;
    debug_pkg::word_t word;
    logic             last;     // final register word of the dump

    modport src (
        output valid, word, last,
        input  ready
    );

    modport dst (
        input  valid, word, last,
        output ready
    );
endinterface

// ==== logic/cmd_controller.sv ====
`timescale 1ns/1ps
`include "debug_params.svh"

module cmd_controller (
    input  logic             i_clock,
    input  logic             i_reset,
    input  logic             i_rx_done,
    input  debug_pkg::byte_t i_rx_data,
    input  logic             i_halt,
    input  logic             i_load_done,
    input  logic             i_dump_done,
    output logic             o_load_en,
    output logic             o_dump_start,
    output logic             o_pipeline_enable
);

    debug_pkg::ctrl_state_t state;
    debug_pkg::ctrl_state_t state_next;
    logic                   step_mode;          // dump returns to STEP_WAIT when set
    logic                   step_mode_next;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state     <= debug_pkg::IDLE;
            step_mode <= 1'b0;
        end else begin
            state     <= state_next;
            step_mode <= step_mode_next;
        end
    end

    always_comb begin
        state_next     = state;
        step_mode_next = step_mode;
        case (state)
            debug_pkg::IDLE: begin
                if (i_rx_done && i_rx_data == `DU_CMD_WRITE_IM) begin
                    state_next = debug_pkg::LOAD;
                end else if (i_rx_done && i_rx_data == `DU_CMD_SEND_INFO) begin
                    state_next = debug_pkg::DUMP;
                end
            end
            debug_pkg::LOAD: begin
                if (i_load_done) state_next = debug_pkg::READY;
            end
            debug_pkg::READY: begin
                if (i_rx_done && i_rx_data == `DU_CMD_STEP_MODE) begin
                    state_next     = debug_pkg::STEP_WAIT;
                    step_mode_next = 1'b1;
                end else if (i_rx_done && i_rx_data == `DU_CMD_CONTINUE) begin
                    state_next = debug_pkg::RUN;
                end
            end
            debug_pkg::RUN: begin
                if (i_halt) begin
                    state_next     = debug_pkg::DUMP;
                    step_mode_next = 1'b0;
                end
            end
            debug_pkg::STEP_WAIT: begin
                if (i_halt) begin                       // program ended, leave step mode
                    state_next     = debug_pkg::DUMP;
                    step_mode_next = 1'b0;
                end else if (i_rx_done && i_rx_data == `DU_CMD_STEP) begin
                    state_next = debug_pkg::STEP_EXEC;
                end else if (i_rx_done && i_rx_data == `DU_CMD_CONTINUE) begin
                    state_next     = debug_pkg::RUN;
                    step_mode_next = 1'b0;
                end
            end
            debug_pkg::STEP_EXEC: state_next = debug_pkg::DUMP;    // one clock of pipeline
            debug_pkg::DUMP: begin
                if (i_dump_done) begin
                    state_next = step_mode ? debug_pkg::STEP_WAIT : debug_pkg::IDLE;
                end
            end
            default: state_next = debug_pkg::IDLE;
        endcase
    end

    assign o_load_en         = (state == debug_pkg::LOAD);
    assign o_dump_start      = (state_next == debug_pkg::DUMP) && (state != debug_pkg::DUMP);
    assign o_pipeline_enable = (state == debug_pkg::RUN) || (state == debug_pkg::STEP_EXEC);

    a_dump_start_cause: assert property (
        @(posedge i_clock) disable iff (i_reset)
        o_dump_start |-> i_halt || (state == debug_pkg::STEP_EXEC)
                         || (i_rx_done && i_rx_data == `DU_CMD_SEND_INFO)
    ) else $error("dump start without halt, step or info command");

endmodule

// ==== logic/im_loader.sv ====
`timescale 1ns/1ps
`include "debug_params.svh"

module im_loader (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_load_en,
    input  logic                i_rx_done,
    input  debug_pkg::byte_t    i_rx_data,
    output logic                o_im_write_enable,
    output debug_pkg::im_addr_t o_im_addr,
    output debug_pkg::byte_t    o_im_data,
    output logic                o_load_done
);

    debug_pkg::im_addr_t count;         // next address to write
    logic                take;
    logic                take_last;

    assign take      = i_load_en && i_rx_done;
    assign take_last = take && (count == debug_pkg::im_addr_t'(`DU_IM_BYTES - 1));

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            count             <= '0;
            o_im_write_enable <= 1'b0;
            o_load_done       <= 1'b0;
        end else begin
            o_im_write_enable <= take;
            o_load_done       <= take_last;     // rides with the final write
            if (take_last) begin
                count <= '0;
            end else if (take) begin
                count <= count + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (take) begin
            o_im_addr <= count;
            o_im_data <= i_rx_data;
        end
    end

    a_addr_in_range: assert property (
        @(posedge i_clock) disable iff (i_reset)
        o_im_write_enable |-> (o_im_addr < `DU_IM_BYTES)
    ) else $error("instruction memory write past the load length");

endmodule

// ==== logic/dump_sequencer.sv ====
`timescale 1ns/1ps
`include "debug_params.svh"

module dump_sequencer (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_dump_start,
    input  debug_pkg::word_t    i_pc_value,
    input  debug_pkg::word_t    i_dm_data,
    input  debug_pkg::word_t    i_rb_data,
    output debug_pkg::dm_addr_t o_dm_addr,
    output debug_pkg::rb_addr_t o_rb_addr,
    word_if.src                 w_out
);

    debug_pkg::dump_src_t phase;
    logic                 fetch;        // address settled, capture next cycle's word
    logic                 xfer;
    logic                 dm_last;
    logic                 rb_last;

    assign xfer    = w_out.valid && w_out.ready;
    assign dm_last = (o_dm_addr == debug_pkg::dm_addr_t'(`DU_DM_WORDS - 1));
    assign rb_last = (o_rb_addr == debug_pkg::rb_addr_t'(`DU_RB_WORDS - 1));

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            phase       <= debug_pkg::PC;
            fetch       <= 1'b0;
            w_out.valid <= 1'b0;
            w_out.last  <= 1'b0;
            o_dm_addr   <= '0;
            o_rb_addr   <= '0;
        end else if (i_dump_start) begin
            phase       <= debug_pkg::PC;
            fetch       <= 1'b0;
            w_out.valid <= 1'b1;            // pc word is ready at once
            w_out.last  <= 1'b0;
            o_dm_addr   <= '0;
            o_rb_addr   <= '0;
        end else if (fetch) begin
            fetch       <= 1'b0;
            w_out.valid <= 1'b1;
            w_out.last  <= (phase == debug_pkg::RB) && rb_last;
        end else if (xfer) begin
            w_out.valid <= 1'b0;
            if (!w_out.last) begin
                fetch <= 1'b1;
                case (phase)
                    debug_pkg::PC: phase <= debug_pkg::DM;     // dm address already 0
                    debug_pkg::DM: begin
                        if (dm_last) begin
                            phase <= debug_pkg::RB;
                        end else begin
                            o_dm_addr <= o_dm_addr + 1'b1;
                        end
                    end
                    default: o_rb_addr <= o_rb_addr + 1'b1;
                endcase
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_dump_start) begin
            w_out.word <= i_pc_value;
        end else if (fetch) begin
            w_out.word <= (phase == debug_pkg::RB) ? i_rb_data : i_dm_data;
        end
    end

    a_valid_held: assert property (
        @(posedge i_clock) disable iff (i_reset)
        w_out.valid && !w_out.ready |=> w_out.valid && $stable(w_out.word)
    ) else $error("dump word dropped before transfer");

endmodule

// ==== logic/word_tx.sv ====
`timescale 1ns/1ps

module word_tx (
    input  logic             i_clock,
    input  logic             i_reset,
    input  logic             i_tx_done,
    output logic             o_tx_start,
    output debug_pkg::byte_t o_tx_data,
    output logic             o_dump_done,
    word_if.dst              w_in
);

    debug_pkg::word_t word_buf;         // bytes still to send, msb first
    logic [1:0]       byte_cnt;
    logic             busy;
    logic             last_word;
    logic             accept;
    logic             byte_ack;
    logic             launch;

    assign w_in.ready = !busy;
    assign accept     = w_in.valid && !busy;
    assign byte_ack   = o_tx_start && i_tx_done;
    assign launch     = busy && !o_tx_start;   // also gives the low cycle between bytes

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            busy        <= 1'b0;
            byte_cnt    <= '0;
            last_word   <= 1'b0;
            o_tx_start  <= 1'b0;
            o_dump_done <= 1'b0;
        end else begin
            o_dump_done <= 1'b0;
            if (accept) begin
                busy      <= 1'b1;
                byte_cnt  <= '0;
                last_word <= w_in.last;
            end else if (byte_ack) begin
                o_tx_start <= 1'b0;
                byte_cnt   <= byte_cnt + 1'b1;
                if (byte_cnt == 2'd3) begin
                    busy        <= 1'b0;
                    o_dump_done <= last_word;
                end
            end else if (launch) begin
                o_tx_start <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (accept) begin
            word_buf <= w_in.word;
        end else if (launch) begin
            o_tx_data <= word_buf[31:24];
            word_buf  <= {word_buf[23:0], 8'h00};
        end
    end

    a_tx_data_stable: assert property (
        @(posedge i_clock) disable iff (i_reset)
        o_tx_start && !i_tx_done |=> o_tx_start && $stable(o_tx_data)
    ) else $error("tx byte changed before tx done");

endmodule

// ==== logic/debug_unit.sv ====
`timescale 1ns/1ps

module debug_unit (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_halt,
    input  logic                i_rx_done,
    input  debug_pkg::byte_t    i_rx_data,
    input  logic                i_tx_done,
    input  debug_pkg::word_t    i_pc_value,
    input  debug_pkg::word_t    i_dm_data,
    input  debug_pkg::word_t    i_rb_data,
    output logic                o_im_write_enable,
    output debug_pkg::im_addr_t o_im_addr,
    output debug_pkg::byte_t    o_im_data,
    output debug_pkg::dm_addr_t o_dm_addr,
    output debug_pkg::rb_addr_t o_rb_addr,
    output logic                o_tx_start,
    output debug_pkg::byte_t    o_tx_data,
    output logic                o_pipeline_enable
);

    logic load_en;
    logic load_done;
    logic dump_start;
    logic dump_done;

    word_if dump_word ();

    cmd_controller ctrl_i (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_rx_done         (i_rx_done),
        .i_rx_data         (i_rx_data),
        .i_halt            (i_halt),
        .i_load_done       (load_done),
        .i_dump_done       (dump_done),
        .o_load_en         (load_en),
        .o_dump_start      (dump_start),
        .o_pipeline_enable (o_pipeline_enable)
    );

    im_loader loader_i (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_load_en         (load_en),
        .i_rx_done         (i_rx_done),
        .i_rx_data         (i_rx_data),
        .o_im_write_enable (o_im_write_enable),
        .o_im_addr         (o_im_addr),
        .o_im_data         (o_im_data),
        .o_load_done       (load_done)
    );

    dump_sequencer seq_i (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_dump_start (dump_start),
        .i_pc_value   (i_pc_value),
        .i_dm_data    (i_dm_data),
        .i_rb_data    (i_rb_data),
        .o_dm_addr    (o_dm_addr),
        .o_rb_addr    (o_rb_addr),
        .w_out        (dump_word.src)
    );

    word_tx tx_i (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_tx_done   (i_tx_done),
        .o_tx_start  (o_tx_start),
        .o_tx_data   (o_tx_data),
        .o_dump_done (dump_done),
        .w_in        (dump_word.dst)
    );

endmodule

// ==== tests/debug_unit_checker.sv ====
`timescale 1ns/1ps
`include "debug_params.svh"

module debug_unit_checker #(
    parameter int DUMP_BYTES = 4
) (
    input  logic       i_clock,
    input  logic       i_reset,
    input  logic       i_rx_done,
    input  logic [7:0] i_rx_data,
    input  logic       i_halt,
    input  logic       i_tx_done,
    input  logic       i_tx_start,
    input  logic [7:0] i_tx_data,
    input  logic       i_im_write_enable,
    input  logic [7:0] i_im_addr,
    input  logic [7:0] i_im_data,
    input  logic       i_pipeline_enable,
    input  logic       i_run_check,         // continue issued, enable must hold until halt
    input  logic       i_step_check,        // enable only right after a step byte
    input  logic [7:0] i_expected [DUMP_BYTES],
    output int         o_errors,
    output int         o_dumps,
    output int         o_writes
);

    int         errors = 0;
    int         dumps = 0;
    int         writes = 0;
    int         byte_idx = 0;
    int         wr_idx = 0;
    logic       halted = 1'b0;
    logic       prev_reset = 1'b0;
    logic       prev_rx_done = 1'b0;
    logic [7:0] prev_rx_data = '0;
    logic       prev_halt = 1'b0;
    logic       prev_enable = 1'b0;
    logic       prev_start = 1'b0;
    logic       prev_done = 1'b0;
    logic [7:0] prev_tx_data = '0;
    logic       step_cmd;

    assign o_errors = errors;
    assign o_dumps  = dumps;
    assign o_writes = writes;

    task automatic report(input string msg);
        errors++;
        $display("[FAIL] %0t: %s", $time, msg);
    endtask

    always @(posedge i_clock) begin
        step_cmd = prev_rx_done && (prev_rx_data == `DU_CMD_STEP);
        if (prev_reset && (i_pipeline_enable !== 1'b0 || i_im_write_enable !== 1'b0
                           || i_tx_start !== 1'b0)) begin
            report("outputs active right after reset");
        end
        if (i_reset) begin
            byte_idx = 0;
            wr_idx   = 0;
        end else begin
            // one byte of the dump is taken on each tx done
            if (i_tx_start && i_tx_done) begin
                if (i_tx_data !== i_expected[byte_idx]) begin
                    report($sformatf("dump byte %0d is %h, expected %h",
                                     byte_idx, i_tx_data, i_expected[byte_idx]));
                end
                if (byte_idx == DUMP_BYTES - 1) begin
                    byte_idx = 0;
                    dumps++;
                end else begin
                    byte_idx++;
                end
            end
            if (prev_start && !prev_done && (!i_tx_start || i_tx_data !== prev_tx_data)) begin
                report("tx byte changed before tx done");
            end
            if (prev_start && prev_done && i_tx_start) begin
                report("tx start still high after tx done");
            end

            if (i_im_write_enable) begin
                if (!prev_rx_done || i_im_data !== prev_rx_data) begin
                    report($sformatf("im write data %h, rx byte a cycle earlier %h",
                                     i_im_data, prev_rx_data));
                end
                if (i_im_addr !== 8'(wr_idx)) begin
                    report($sformatf("im write address %0d, expected %0d", i_im_addr, wr_idx));
                end
                wr_idx = (wr_idx + 1) % `DU_IM_BYTES;
                writes++;
            end

            if (i_step_check) begin
                if (i_pipeline_enable !== step_cmd) begin
                    report($sformatf("pipeline enable %b, expected %b", i_pipeline_enable,
                                     step_cmd));
                end
            end else if (i_run_check) begin
                if (halted && i_pipeline_enable) begin
                    report("pipeline enable high after halt");
                end
                if (prev_enable && !i_pipeline_enable && !prev_halt) begin
                    report("pipeline enable dropped without halt");
                end
                if (i_halt && i_pipeline_enable) halted = 1'b1;
            end else begin
                halted = 1'b0;
                if (i_pipeline_enable) report("pipeline enable high outside run or step");
            end
        end

        prev_reset   = i_reset;
        prev_rx_done = i_rx_done;
        prev_rx_data = i_rx_data;
        prev_halt    = i_halt;
        prev_enable  = i_pipeline_enable;
        prev_start   = i_tx_start;
        prev_done    = i_tx_done;
        prev_tx_data = i_tx_data;
    end

endmodule

// ==== tests/debug_unit_tb.sv ====
`timescale 1ns/1ps
`include "debug_params.svh"

module debug_unit_tb;

    localparam int DUMP_BYTES = 4 * (1 + `DU_DM_WORDS + `DU_RB_WORDS);
    localparam int WAIT_LIMIT = 5000;       // clock cycles per wait

    logic        clock;
    logic        reset;
    logic        halt;
    logic        rx_done;
    logic [7:0]  rx_data;
    logic        tx_done = 1'b0;
    logic [31:0] pc_value;
    logic [31:0] dm_data;
    logic [31:0] rb_data;
    logic        im_write_enable;
    logic [7:0]  im_addr;
    logic [7:0]  im_data;
    logic [4:0]  dm_addr;
    logic [4:0]  rb_addr;
    logic        tx_start;
    logic [7:0]  tx_data;
    logic        pipeline_enable;
    logic [31:0] dm_mem [`DU_DM_WORDS];
    logic [31:0] rb_mem [`DU_RB_WORDS];
    logic [7:0]  exp_bytes [DUMP_BYTES];
    logic        run_check;
    logic        step_check;
    int          tx_wait = 1;
    int          tb_errors;
    int          chk_errors;
    int          dumps;
    int          writes;

    debug_unit dut_i (
        .i_clock           (clock),
        .i_reset           (reset),
        .i_halt            (halt),
        .i_rx_done         (rx_done),
        .i_rx_data         (rx_data),
        .i_tx_done         (tx_done),
        .i_pc_value        (pc_value),
        .i_dm_data         (dm_data),
        .i_rb_data         (rb_data),
        .o_im_write_enable (im_write_enable),
        .o_im_addr         (im_addr),
        .o_im_data         (im_data),
        .o_dm_addr         (dm_addr),
        .o_rb_addr         (rb_addr),
        .o_tx_start        (tx_start),
        .o_tx_data         (tx_data),
        .o_pipeline_enable (pipeline_enable)
    );

    debug_unit_checker #(.DUMP_BYTES(DUMP_BYTES)) chk_i (
        .i_clock           (clock),
        .i_reset           (reset),
        .i_rx_done         (rx_done),
        .i_rx_data         (rx_data),
        .i_halt            (halt),
        .i_tx_done         (tx_done),
        .i_tx_start        (tx_start),
        .i_tx_data         (tx_data),
        .i_im_write_enable (im_write_enable),
        .i_im_addr         (im_addr),
        .i_im_data         (im_data),
        .i_pipeline_enable (pipeline_enable),
        .i_run_check       (run_check),
        .i_step_check      (step_check),
        .i_expected        (exp_bytes),
        .o_errors          (chk_errors),
        .o_dumps           (dumps),
        .o_writes          (writes)
    );

    assign dm_data = dm_mem[dm_addr];      // memories read combinationally
    assign rb_data = rb_mem[rb_addr];

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // uart transmitter answers each start after 1 to 5 cycles
    always @(negedge clock) begin
        if (tx_done || !tx_start) begin
            tx_done = 1'b0;
            tx_wait = 1 + int'($urandom % 5);
        end else if (tx_wait > 1) begin
            tx_wait--;
        end else begin
            tx_done = 1'b1;
        end
    end

    // pc, then every dm word, then every rb word, msb first
    function automatic void expected_dump();
        int k;
        int b;
        int n;
        n = 0;
        for (b = 3; b >= 0; b--) begin
            exp_bytes[n] = pc_value[8*b +: 8];
            n++;
        end
        for (k = 0; k < `DU_DM_WORDS; k++) begin
            for (b = 3; b >= 0; b--) begin
                exp_bytes[n] = dm_mem[k][8*b +: 8];
                n++;
            end
        end
        for (k = 0; k < `DU_RB_WORDS; k++) begin
            for (b = 3; b >= 0; b--) begin
                exp_bytes[n] = rb_mem[k][8*b +: 8];
                n++;
            end
        end
    endfunction

    task automatic randomize_state();
        pc_value = $urandom;
        foreach (dm_mem[k]) dm_mem[k] = $urandom;
        foreach (rb_mem[k]) rb_mem[k] = $urandom;
        expected_dump();
    endtask

    task automatic report_timeout(input string what);
        tb_errors++;
        $display("%s at %0t", what, $time);
    endtask

    task automatic send_byte(input logic [7:0] b);
        rx_data = b;
        rx_done = 1'b1;
        @(negedge clock);
        rx_done = 1'b0;
    endtask

    task automatic wait_dumps(input int target);
        int n;
        n = 0;
        while (dumps < target && n < WAIT_LIMIT) begin
            @(negedge clock);
            n++;
        end
        if (dumps < target) report_timeout("timed out waiting for a dump to finish");
        @(negedge clock);                   // controller leaves DUMP a cycle later
    endtask

    task automatic wait_enable();
        int n;
        n = 0;
        while (!pipeline_enable && n < WAIT_LIMIT) begin
            @(negedge clock);
            n++;
        end
        if (!pipeline_enable) report_timeout("timed out waiting for the pipeline enable");
    endtask

    task automatic load_program();
        int start;
        start = writes;
        send_byte(`DU_CMD_WRITE_IM);
        repeat (`DU_IM_BYTES) send_byte(8'($urandom));
        repeat (2) @(negedge clock);
        if (writes - start != `DU_IM_BYTES) begin
            tb_errors++;
            $display("[FAIL] %0t: %0d im writes, expected %0d", $time, writes - start,
                     `DU_IM_BYTES);
        end
    endtask

    initial begin
        void'($urandom(12));
        reset      = 1'b1;
        halt       = 1'b0;
        rx_done    = 1'b0;
        rx_data    = '0;
        run_check  = 1'b0;
        step_check = 1'b0;
        tb_errors  = 0;
        randomize_state();
        repeat (2) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);

        send_byte(`DU_CMD_SEND_INFO);
        wait_dumps(1);

        load_program();                     // accepted only in idle
        randomize_state();
        run_check = 1'b1;
        send_byte(`DU_CMD_CONTINUE);
        wait_enable();
        repeat (20) @(negedge clock);
        halt = 1'b1;
        @(negedge clock);
        halt = 1'b0;
        wait_dumps(2);
        run_check = 1'b0;

        load_program();
        step_check = 1'b1;
        send_byte(`DU_CMD_STEP_MODE);
        randomize_state();
        send_byte(`DU_CMD_STEP);
        wait_dumps(3);
        randomize_state();
        send_byte(`DU_CMD_STEP);            // only taken if back in step mode
        wait_dumps(4);
        step_check = 1'b0;
        repeat (5) @(negedge clock);

        $display("errors: checker %0d, testbench %0d", chk_errors, tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== debug_unit.f ====
+incdir+include
logic/debug_pkg.sv
logic/word_if.sv
logic/cmd_controller.sv
logic/im_loader.sv
logic/dump_sequencer.sv
logic/word_tx.sv
logic/debug_unit.sv
tests/debug_unit_checker.sv
tests/debug_unit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the debug unit testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module debug_unit_tb \
    -f debug_unit.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output="$(./obj_dir/Vdebug_unit_tb)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -Fxq "PASS: all tests" <<< "$output"; then
    exit 0
fi
exit 1
